// ==== flist.f ====
hdl/tuart_pkg.sv
hdl/cmd_pkg.sv
hdl/cmd_if.sv
hdl/resp_if.sv
hdl/tuart_rx.sv
hdl/cmd_decode.sv
hdl/cmd_exec.sv
hdl/resp_pack.sv
hdl/tuart_tx.sv
hdl/tuart_top.sv
test/tuart_top_chk.sv
test/tb_tuart_top.sv

// ==== test/tb_tuart_top.sv ====
`timescale 1ns/1ns

module tb_tuart_top import tuart_pkg::*, cmd_pkg::*; ();

  localparam int PAIR_CYCLES = 720;  // one command and its response rounded up
  localparam int NUM_PAIRS   = 19;
  localparam int XOFF_HOLD   = 1000;
  localparam int TIMEOUT_CYCLES = NUM_PAIRS * PAIR_CYCLES + XOFF_HOLD + 2000;

  logic clk_i;
  logic rst_in;
  logic rx_i;
  logic tx_o;

  logic [7:0]  reg_model [REG_COUNT];
  logic [15:0] lfsr_state;
  int          cycles;
  int          checks;
  int          errors;
  int          ntests;

  tuart_top DUT (
    .clk_i  (clk_i),
    .rst_in (rst_in),
    .rx_i   (rx_i),
    .tx_o   (tx_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not complete", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // galois taps 16 14 13 11
  endfunction

  task automatic next_rand_byte(output logic [7:0] b);
    for (int k = 0; k < 8; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      b[k] = lfsr_state[0];
    end
  endtask

  task automatic compare_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch %s got 0x%02h expected 0x%02h", name, got, exp);
      errors++;
    end
  endtask

  // one frame with an idle bit time in front
  task automatic send_byte(input logic [7:0] b, input logic bad_stop);
    @(negedge clk_i);
    rx_i = 1'b1;
    repeat (CLK_PER_SAMPLE) @(negedge clk_i);
    rx_i = 1'b0;
    repeat (CLK_PER_SAMPLE) @(negedge clk_i);
    for (int j = 0; j < WORD_BITS; j++) begin
      rx_i = b[j];  // lsb first
      repeat (CLK_PER_SAMPLE) @(negedge clk_i);
    end
    rx_i = !bad_stop;
    repeat (CLK_PER_SAMPLE) @(negedge clk_i);
    rx_i = 1'b1;
  endtask

  task automatic send_cmd(input logic [7:0] op, input logic [7:0] addr,
                          input logic [7:0] operand, input logic [7:0] sum_mask);
    send_byte(op, 1'b0);
    send_byte(addr, 1'b0);
    send_byte(operand, 1'b0);
    send_byte(op ^ addr ^ operand ^ sum_mask, 1'b0);
  endtask

  // samples tx_o mid bit and puts byte 0 in word[7:0]
  task automatic collect_resp(output logic [31:0] word);
    logic [7:0] b;
    for (int i = 0; i < CMD_WORDS; i++) begin
      @(negedge clk_i);
      while (tx_o) @(negedge clk_i);
      repeat (CLK_PER_SAMPLE / 2) @(negedge clk_i);
      checks++;
      assert (!tx_o) else begin
        $display("start bit of response byte %0d did not stay low", i);
        errors++;
      end
      for (int j = 0; j < WORD_BITS; j++) begin
        repeat (CLK_PER_SAMPLE) @(negedge clk_i);
        b[j] = tx_o;
      end
      repeat (CLK_PER_SAMPLE) @(negedge clk_i);
      checks++;
      assert (tx_o) else begin
        $display("stop bit of response byte %0d was low", i);
        errors++;
      end
      word[8*i +: 8] = b;
    end
  endtask

  // expected status and value from the register model, which it updates
  task automatic predict(input logic [7:0] op, input logic [7:0] addr,
                         input logic [7:0] operand, input logic bad_sum,
                         output logic [7:0] st, output logic [7:0] val);
    logic [REG_ADDR_BITS-1:0] ra;
    ra  = addr[REG_ADDR_BITS-1:0];
    val = 8'h00;
    if (bad_sum) st = ST_BAD_SUM;
    else if (!(op == OP_READ || op == OP_WRITE || op == OP_ADD || op == OP_XOR))
      st = ST_BAD_OP;
    else if (addr >= REG_COUNT) st = ST_BAD_ADDR;
    else begin
      st = ST_OK;
      case (op)
        OP_WRITE: reg_model[ra] = operand;
        OP_ADD:   reg_model[ra] = reg_model[ra] + operand;  // modulo 256
        OP_XOR:   reg_model[ra] = reg_model[ra] ^ operand;
        default:  ;
      endcase
      val = reg_model[ra];
    end
  endtask

  task automatic check_resp(input logic [31:0] word, input logic [7:0] st,
                            input logic [7:0] addr, input logic [7:0] val);
    compare_byte("resp status", word[7:0], st);
    compare_byte("resp addr", word[15:8], addr);
    compare_byte("resp value", word[23:16], val);
    compare_byte("resp checksum", word[31:24], st ^ addr ^ val);
  endtask

  task automatic run_cmd(input logic [7:0] op, input logic [7:0] addr,
                         input logic [7:0] operand, input logic [7:0] sum_mask);
    logic [31:0] word;
    logic [7:0]  st;
    logic [7:0]  val;
    predict(op, addr, operand, sum_mask != 8'h00, st, val);
    fork
      send_cmd(op, addr, operand, sum_mask);
      collect_resp(word);  // response may start inside the last stop bit
    join
    check_resp(word, st, addr, val);
  endtask

  task automatic report_test(input string name, input int e0);
    ntests++;
    $display("test %s finished, %0d errors", name, errors - e0);
  endtask

  task automatic test_write_read();
    int e0;
    e0 = errors;
    for (int a = 0; a < REG_COUNT; a++) begin
      run_cmd(OP_WRITE, 8'(a), 8'h5A ^ 8'(a * 23), 8'h00);
      run_cmd(OP_READ, 8'(a), 8'h00, 8'h00);
    end
    report_test("write_read", e0);
  endtask

  task automatic test_arith();
    int         e0;
    logic [7:0] r;
    e0 = errors;
    next_rand_byte(r);
    run_cmd(OP_ADD, 8'd0, r, 8'h00);
    next_rand_byte(r);
    run_cmd(OP_XOR, 8'd1, r, 8'h00);
    run_cmd(OP_WRITE, 8'd3, 8'hF0, 8'h00);
    next_rand_byte(r);
    run_cmd(OP_ADD, 8'd3, r | 8'h80, 8'h00);  // sum passes 0xff
    report_test("arith", e0);
  endtask

  task automatic test_reject();
    int e0;
    e0 = errors;
    run_cmd(OP_WRITE, 8'd1, 8'hEE, 8'h5A);  // corrupt checksum
    run_cmd(8'h7E, 8'd2, 8'h33, 8'h00);
    run_cmd(OP_WRITE, 8'd5, 8'h44, 8'h00);
    run_cmd(OP_READ, 8'd1, 8'h00, 8'h00);
    run_cmd(OP_READ, 8'd2, 8'h00, 8'h00);
    report_test("reject", e0);
  endtask

  task automatic test_framing();
    int e0;
    e0 = errors;
    send_byte(8'hA5, 1'b1);
    run_cmd(OP_WRITE, 8'd0, 8'h96, 8'h00);
    report_test("framing", e0);
  endtask

  task automatic test_flow();
    int          e0;
    int          low_cnt;
    logic [31:0] word;
    logic [7:0]  st;
    logic [7:0]  val;
    e0 = errors;
    send_byte(XOFF_CHAR, 1'b0);
    predict(OP_READ, 8'd2, 8'h00, 1'b0, st, val);
    send_cmd(OP_READ, 8'd2, 8'h00, 8'h00);
    low_cnt = 0;
    repeat (XOFF_HOLD) begin
      @(negedge clk_i);
      if (!tx_o) low_cnt++;
    end
    checks++;
    assert (low_cnt == 0) else begin
      $display("response started on tx_o while XOFF was in force");
      errors++;
    end
    fork
      send_byte(XON_CHAR, 1'b0);
      collect_resp(word);
    join
    check_resp(word, st, 8'd2, val);
    report_test("flow", e0);
  endtask

  initial begin
    clk_i      = 1'b0;
    rst_in     = 1'b0;
    rx_i       = 1'b1;  // line idles high
    cycles     = 0;
    checks     = 0;
    errors     = 0;
    ntests     = 0;
    lfsr_state = 16'd40;
    for (int i = 0; i < REG_COUNT; i++) reg_model[i] = 8'h00;
    repeat (10) @(negedge clk_i);
    rst_in = 1'b1;
    repeat (4) @(negedge clk_i);

    test_write_read();
    test_arith();
    test_reject();
    test_framing();
    test_flow();

    // bound assertion failures count as errors too
    errors += DUT.u_chk.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d", ntests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== test/tuart_top_chk.sv ====
`timescale 1ns/1ns

module tuart_top_chk (
  input logic clk_i,
  input logic rst_in,
  input logic tx_line_i,
  input logic tx_rdy_i,
  input logic cmd_vld_i,
  input logic res_vld_i
);

  int fail_cnt = 0;  // failed assertions so far

  // idle transmitter keeps the stop level on the line
  idle_line_high: assert property (@(posedge clk_i) disable iff (!rst_in)
    tx_rdy_i |-> tx_line_i)
    else begin
      $error("tx line low while the transmitter is idle");
      fail_cnt++;
    end

  cmd_vld_pulse: assert property (@(posedge clk_i) disable iff (!rst_in)
    cmd_vld_i |=> !cmd_vld_i)
    else begin
      $error("cmd_vld held for more than one cycle");
      fail_cnt++;
    end

  res_vld_pulse: assert property (@(posedge clk_i) disable iff (!rst_in)
    res_vld_i |=> !res_vld_i)
    else begin
      $error("res_vld held for more than one cycle");
      fail_cnt++;
    end

  // executor answers every command on the next cycle
  res_after_cmd: assert property (@(posedge clk_i) disable iff (!rst_in)
    cmd_vld_i |=> res_vld_i)
    else begin
      $error("res_vld missing one cycle after cmd_vld");
      fail_cnt++;
    end

  res_needs_cmd: assert property (@(posedge clk_i) disable iff (!rst_in)
    res_vld_i |-> $past(cmd_vld_i))
    else begin
      $error("res_vld without a cmd_vld one cycle before");
      fail_cnt++;
    end

  line_high_after_reset: assert property (@(posedge clk_i)
    !rst_in |=> tx_line_i [*4])
    else begin
      $error("tx line not high after reset");
      fail_cnt++;
    end

endmodule

bind tuart_top tuart_top_chk u_chk (
  .clk_i     (clk_i),
  .rst_in    (rst_in),
  .tx_line_i (tx_o),
  .tx_rdy_i  (tx_rdy),
  .cmd_vld_i (cmd_bus.cmd_vld),
  .res_vld_i (res_bus.res_vld)
);

// ==== hdl/tuart_top.sv ====
`timescale 1ns/1ns

module tuart_top (
  input  logic clk_i,
  input  logic rst_in,
  input  logic rx_i,
  output logic tx_o
);

  // receiver to decoder
  logic       rx_stb;
  logic [7:0] rx_byte;

  // flow control pulses
  logic xstb;
  logic xon;
  logic xoff;

  // response handshake
  logic        tx_stb;
  logic        tx_rdy;
  logic [31:0] tx_data;

  cmd_if  cmd_bus ();
  resp_if res_bus ();

  tuart_rx u_rx (
    .clk_i     (clk_i),
    .rst_in    (rst_in),
    .rx_i      (rx_i),
    .rx_stb_o  (rx_stb),
    .rx_byte_o (rx_byte)
  );

  cmd_decode u_dec (
    .clk_i     (clk_i),
    .rst_in    (rst_in),
    .rx_stb_i  (rx_stb),
    .rx_byte_i (rx_byte),
    .cmd       (cmd_bus.dec),
    .xstb_o    (xstb),
    .xon_o     (xon),
    .xoff_o    (xoff)
  );

  cmd_exec u_exec (
    .clk_i  (clk_i),
    .rst_in (rst_in),
    .cmd    (cmd_bus.exe),
    .res    (res_bus.exe)
  );

  resp_pack u_pack (
    .clk_i     (clk_i),
    .rst_in    (rst_in),
    .res       (res_bus.pack),
    .tx_rdy_i  (tx_rdy),
    .tx_stb_o  (tx_stb),
    .tx_data_o (tx_data)
  );

  tuart_tx u_tx (
    .clk_i  (clk_i),
    .rst_in (rst_in),
    .stb_i  (tx_stb),
    .rdy_o  (tx_rdy),
    .tx_o   (tx_o),
    .xstb_i (xstb),
    .xoff_i (xoff),
    .xon_i  (xon),
    .data_i (tx_data)
  );

endmodule

// ==== hdl/tuart_tx.sv ====
`timescale 1ns/1ns

module tuart_tx import tuart_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_in,
  input  logic                             stb_i,   // start a response
  output logic                             rdy_o,   // idle, ready for a response
  output logic                             tx_o,
  input  logic                             xstb_i,  // flow control update
  input  logic                             xoff_i,
  input  logic                             xon_i,
  input  logic [WORD_BITS*CMD_WORDS-1:0]   data_i
);

  typedef enum logic [1:0] {IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
  typedef logic [$clog2(CLK_PER_SAMPLE)-1:0] tcnt_t;
  typedef logic [$clog2(WORD_BITS)-1:0]      bcnt_t;
  typedef logic [$clog2(CMD_WORDS)-1:0]      wcnt_t;

  tx_state_t state;
  tx_state_t state_next;

  logic [WORD_BITS*CMD_WORDS-1:0] shft_reg;
  logic [WORD_BITS*CMD_WORDS-1:0] shft_reg_next;

  tcnt_t time_cnt;
  tcnt_t time_cnt_next;
  bcnt_t bit_cnt;
  bcnt_t bit_cnt_next;
  wcnt_t word_cnt;
  wcnt_t word_cnt_next;

  xctrl_t xctrl;

  assign rdy_o = (state == IDLE);

  always_comb begin
    case (state)
      TX_START: tx_o = 1'b0;
      TX_DATA:  tx_o = shft_reg[0];
      default:  tx_o = 1'b1;  // idle and stop bit
    endcase
  end

  always_comb begin
    state_next    = state;
    shft_reg_next = shft_reg;
    time_cnt_next = time_cnt;
    bit_cnt_next  = bit_cnt;
    word_cnt_next = word_cnt;

    case (state)
      // xoff only holds back a new response
      IDLE: begin
        if (stb_i && xctrl == XON) begin
          state_next    = TX_START;
          shft_reg_next = data_i;
          time_cnt_next = tcnt_t'(CLK_PER_SAMPLE - 1);
          word_cnt_next = wcnt_t'(CMD_WORDS - 1);
        end
      end

      TX_START: begin
        time_cnt_next = time_cnt - 1'b1;
        if (time_cnt == '0) begin
          state_next    = TX_DATA;
          time_cnt_next = tcnt_t'(CLK_PER_SAMPLE - 1);
          bit_cnt_next  = bcnt_t'(WORD_BITS - 1);
        end
      end

      TX_DATA: begin
        time_cnt_next = time_cnt - 1'b1;
        if (time_cnt == '0) begin
          time_cnt_next = tcnt_t'(CLK_PER_SAMPLE - 1);
          bit_cnt_next  = bit_cnt - 1'b1;
          shft_reg_next = shft_reg >> 1;  // lsb first, low byte first
          if (bit_cnt == '0) state_next = TX_STOP;
        end
      end

      TX_STOP: begin
        time_cnt_next = time_cnt - 1'b1;
        if (time_cnt == '0) begin
          time_cnt_next = tcnt_t'(CLK_PER_SAMPLE - 1);
          word_cnt_next = word_cnt - 1'b1;
          // next byte follows straight after the stop bit
          state_next = (word_cnt == '0) ? IDLE : TX_START;
        end
      end

      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // datapath and counters, loaded on accept
  always_ff @(posedge clk_i) begin
    shft_reg <= shft_reg_next;
    time_cnt <= time_cnt_next;
    bit_cnt  <= bit_cnt_next;
    word_cnt <= word_cnt_next;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      xctrl <= XON;
    end else if (xstb_i) begin
      if (xon_i)       xctrl <= XON;
      else if (xoff_i) xctrl <= XOFF;
    end
  end

endmodule

// ==== hdl/resp_pack.sv ====
`timescale 1ns/1ns

module resp_pack (
  input  logic        clk_i,
  input  logic        rst_in,
  resp_if.pack        res,
  input  logic        tx_rdy_i,
  output logic        tx_stb_o,
  output logic [31:0] tx_data_o
);

  logic        pending;  // one response waiting for the transmitter
  logic        rdy_q;
  logic [31:0] word;
  logic        accepted;

  assign tx_stb_o  = pending;
  assign tx_data_o = word;

  // transmitter took the word when its ready level drops
  assign accepted = pending && rdy_q && !tx_rdy_i;

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      pending <= 1'b0;
      rdy_q   <= 1'b1;
    end else begin
      rdy_q <= tx_rdy_i;
      if (accepted) begin
        pending <= 1'b0;
      end else if (res.res_vld) begin
        pending <= 1'b1;
      end
    end
  end

  // results arriving while one is pending are dropped
  always_ff @(posedge clk_i) begin
    if (res.res_vld && !pending) begin
      word <= {res.status ^ res.addr ^ res.value,  // checksum goes out last
               res.value,
               res.addr,
               res.status};
    end
  end

endmodule

// ==== hdl/cmd_exec.sv ====
`timescale 1ns/1ns

module cmd_exec import cmd_pkg::*; (
  input  logic clk_i,
  input  logic rst_in,
  cmd_if.exe   cmd,
  resp_if.exe  res
);

  logic [7:0] regs [REG_COUNT];

  logic [REG_ADDR_BITS-1:0] idx;
  logic [7:0]               cur;
  logic [7:0]               nxt;
  logic                     ok;

  // address range already checked by the decoder
  assign idx = cmd.addr[REG_ADDR_BITS-1:0];
  assign ok  = (cmd.status == ST_OK);
  assign cur = regs[idx];

  always_comb begin
    case (cmd.op)
      OP_WRITE: nxt = cmd.operand;
      OP_ADD:   nxt = cur + cmd.operand;  // wraps modulo 256
      OP_XOR:   nxt = cur ^ cmd.operand;
      default:  nxt = cur;                // read
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
      res.res_vld <= 1'b0;
    end else begin
      res.res_vld <= cmd.cmd_vld;
      if (cmd.cmd_vld && ok) regs[idx] <= nxt;
    end
  end

  // result fields
  always_ff @(posedge clk_i) begin
    if (cmd.cmd_vld) begin
      res.status <= cmd.status;
      res.addr   <= cmd.addr;
      res.value  <= ok ? nxt : 8'h00;  // rejected commands report zero
    end
  end

endmodule

// ==== hdl/cmd_decode.sv ====
`timescale 1ns/1ns

module cmd_decode import tuart_pkg::*, cmd_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_in,
  input  logic       rx_stb_i,
  input  logic [7:0] rx_byte_i,
  cmd_if.dec         cmd,
  output logic       xstb_o,
  output logic       xon_o,
  output logic       xoff_o
);

  logic [$clog2(CMD_WORDS)-1:0] byte_idx;

  logic [7:0] op_byte;
  logic [7:0] addr_byte;
  logic [7:0] operand_byte;
  logic [7:0] csum;  // xor of the bytes so far

  logic         is_flow;
  logic         op_known;
  resp_status_t status_nxt;

  assign cmd.op      = cmd_op_t'(op_byte);
  assign cmd.addr    = addr_byte;
  assign cmd.operand = operand_byte;

  // flow characters only count between commands
  assign is_flow = (byte_idx == '0) &&
                   (rx_byte_i == XON_CHAR || rx_byte_i == XOFF_CHAR);

  always_comb begin
    case (op_byte)
      OP_READ, OP_WRITE, OP_ADD, OP_XOR: op_known = 1'b1;
      default:                           op_known = 1'b0;
    endcase
  end

  // checks in priority order, rx_byte_i is the checksum byte here
  always_comb begin
    if (csum != rx_byte_i)      status_nxt = ST_BAD_SUM;
    else if (!op_known)         status_nxt = ST_BAD_OP;
    else if (addr_byte >= REG_COUNT) status_nxt = ST_BAD_ADDR;
    else                        status_nxt = ST_OK;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      byte_idx    <= '0;
      cmd.cmd_vld <= 1'b0;
      xstb_o      <= 1'b0;
      xon_o       <= 1'b0;
      xoff_o      <= 1'b0;
    end else begin
      cmd.cmd_vld <= 1'b0;
      xstb_o      <= 1'b0;
      xon_o       <= 1'b0;
      xoff_o      <= 1'b0;
      if (rx_stb_i) begin
        if (is_flow) begin
          xstb_o <= 1'b1;
          xon_o  <= (rx_byte_i == XON_CHAR);
          xoff_o <= (rx_byte_i == XOFF_CHAR);
        end else begin
          byte_idx <= byte_idx + 1'b1;  // wraps after the checksum byte
          if (int'(byte_idx) == CMD_WORDS - 1) cmd.cmd_vld <= 1'b1;
        end
      end
    end
  end

  // field capture
  always_ff @(posedge clk_i) begin
    if (rx_stb_i && !is_flow) begin
      case (byte_idx)
        2'd0: begin
          op_byte <= rx_byte_i;
          csum    <= rx_byte_i;
        end
        2'd1: begin
          addr_byte <= rx_byte_i;
          csum      <= csum ^ rx_byte_i;
        end
        2'd2: begin
          operand_byte <= rx_byte_i;
          csum         <= csum ^ rx_byte_i;
        end
        default: cmd.status <= status_nxt;
      endcase
    end
  end

endmodule

// ==== hdl/tuart_rx.sv ====
`timescale 1ns/1ns

module tuart_rx import tuart_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_in,
  input  logic       rx_i,
  output logic       rx_stb_o,
  output logic [7:0] rx_byte_o
);

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_t;
  typedef logic [$clog2(CLK_PER_SAMPLE)-1:0] tcnt_t;
  typedef logic [$clog2(WORD_BITS)-1:0]      bcnt_t;

  rx_state_t state;

  logic rx_meta;
  logic rx_sync;
  logic rx_last;  // previous synchronised level, for edge detect

  tcnt_t          time_cnt;
  bcnt_t          bit_cnt;
  logic [WORD_BITS-1:0] shft_reg;

  assign rx_byte_o = shft_reg;

  // two flop synchroniser plus one flop for the falling edge
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_last <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_last <= rx_sync;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state    <= IDLE;
      rx_stb_o <= 1'b0;
    end else begin
      rx_stb_o <= 1'b0;
      case (state)
        IDLE: begin
          // only a falling edge starts a frame, a stuck low line after
          // a framing error is ignored
          if (rx_last && !rx_sync) state <= START;
        end

        START: begin
          if (time_cnt == '0) state <= rx_sync ? IDLE : DATA;  // glitch check
        end

        DATA: begin
          if (time_cnt == '0 && bit_cnt == '0) state <= STOP;
        end

        STOP: begin
          if (time_cnt == '0) begin
            rx_stb_o <= rx_sync;  // no strobe on a framing error
            state    <= IDLE;
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

  // bit timing and data shift
  always_ff @(posedge clk_i) begin
    case (state)
      IDLE: begin
        time_cnt <= tcnt_t'(CLK_PER_SAMPLE / 2 - 1);  // half bit to mid start
        bit_cnt  <= bcnt_t'(WORD_BITS - 1);
      end

      DATA: begin
        time_cnt <= time_cnt - 1'b1;
        if (time_cnt == '0) begin
          time_cnt <= tcnt_t'(CLK_PER_SAMPLE - 1);
          bit_cnt  <= bit_cnt - 1'b1;
          shft_reg <= {rx_sync, shft_reg[WORD_BITS-1:1]};  // lsb first
        end
      end

      default: begin  // START and STOP
        time_cnt <= time_cnt - 1'b1;
        if (time_cnt == '0) time_cnt <= tcnt_t'(CLK_PER_SAMPLE - 1);
      end
    endcase
  end

endmodule

// ==== hdl/resp_if.sv ====
`timescale 1ns/1ns

interface resp_if;

  logic       res_vld;  // one cycle strobe
  logic [7:0] status;
  logic [7:0] addr;
  logic [7:0] value;    // register content after the operation

  modport exe (output res_vld, output status, output addr, output value);
  modport pack (input res_vld, input status, input addr, input value);

endinterface

// ==== hdl/cmd_if.sv ====
`timescale 1ns/1ns

interface cmd_if import cmd_pkg::*; ();

  logic         cmd_vld;  // one cycle strobe
  cmd_op_t      op;
  logic [7:0]   addr;
  logic [7:0]   operand;
  resp_status_t status;   // result of the command checks

  // decoder side
  modport dec (output cmd_vld, output op, output addr, output operand, output status);

  // executor side
  modport exe (input cmd_vld, input op, input addr, input operand, input status);

endinterface

// ==== hdl/cmd_pkg.sv ====
package cmd_pkg;

  // command opcodes, first byte of a command
  typedef enum logic [7:0] {
    OP_READ  = 8'h01,
    OP_WRITE = 8'h02,
    OP_ADD   = 8'h03,
    OP_XOR   = 8'h04
  } cmd_op_t;

  // response status, first byte of a response
  typedef enum logic [7:0] {
    ST_OK       = 8'h00,
    ST_BAD_SUM  = 8'h01,
    ST_BAD_OP   = 8'h02,
    ST_BAD_ADDR = 8'h03
  } resp_status_t;

  // register file
  localparam int REG_COUNT     = 4;
  localparam int REG_ADDR_BITS = $clog2(REG_COUNT);

endpackage

// ==== hdl/tuart_pkg.sv ====
package tuart_pkg;

  // serial frame: 1 start, WORD_BITS data, 1 stop, no parity
  localparam int WORD_BITS      = 8;
  localparam int CMD_WORDS      = 4;  // bytes per command and per response
  localparam int CLK_PER_SAMPLE = 8;  // clock cycles per bit time

  // software flow control characters
  localparam logic [7:0] XON_CHAR  = 8'h11;
  localparam logic [7:0] XOFF_CHAR = 8'h13;

  // transmit permission
  typedef enum logic {
    XON,
    XOFF
  } xctrl_t;

endpackage
